// ==== logic/ft_bus_pkg.sv ====
package ft_bus_pkg;

    ////////////////////
    // chip bus widths
    ////////////////////

    // ft601 in 245 sync fifo mode, 32 bit variant
    localparam int bus_data_w = 32;
    localparam int bus_be_w   = 4;   // one enable per byte lane

    ////////////////////
    // arbiter types
    ////////////////////

    // bus ownership sequence
    typedef enum logic [1:0] {
        st_idle  = 2'd0,   // nobody on the bus, oe_n high
        st_bta   = 2'd1,   // turnaround, chip takes the bus
        st_read  = 2'd2,   // chip drives, rd_n low
        st_write = 2'd3    // fpga drives, wr_n strobed by tx port
    } bus_state_t;

    // last direction that held a grant
    typedef enum logic {
        dir_rx = 1'b0,
        dir_tx = 1'b1
    } bus_dir_t;

endpackage

// ==== logic/ft_stream_pkg.sv ====
package ft_stream_pkg;

    import ft_bus_pkg::*;

    ////////////////////
    // stream payload
    ////////////////////

    // one chip bus beat as carried on the streams
    // 36 bits packed, data in the upper part
    typedef struct packed {
        logic [bus_data_w-1:0] data;   // payload word
        logic [bus_be_w-1:0]   be;     // byte lanes valid
    } stream_word_t;

    ////////////////////
    // buffering
    ////////////////////

    // port fifo depth unless the top says otherwise
    // keep it a power of two, pointers wrap on their own
    localparam int default_fifo_depth = 16;

endpackage

// ==== logic/word_fifo.sv ====
`timescale 1ns/1ps

// show-ahead fifo, head word visible without a pop
module word_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  depth     = 16            // power of two, at least 2
) (
    input  logic                         clk,
    input  logic                         arst_n,
    // write side
    input  payload_t                     in_word,
    input  logic                         in_valid,
    output logic                         in_ready,
    // read side
    output payload_t                     out_word,
    output logic                         out_valid,
    input  logic                         out_ready,
    // empty entries left
    output logic [$clog2(depth+1)-1:0]   free_cnt
);

    localparam int addr_w = $clog2(depth);
    localparam int cnt_w  = $clog2(depth + 1);

    payload_t           mem [depth];    // storage, no reset
    logic [addr_w-1:0]  wr_ptr;
    logic [addr_w-1:0]  rd_ptr;
    logic [cnt_w-1:0]   cnt;            // words held
    logic [cnt_w-1:0]   cnt_nxt;
    logic               push;
    logic               pop;

    ////////////////////
    // handshakes
    ////////////////////

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    // push and pop together leave the count alone
    assign cnt_nxt = cnt + cnt_w'(push) - cnt_w'(pop);

    ////////////////////
    // storage
    ////////////////////

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_word;
        end
    end

    assign out_word  = mem[rd_ptr];         // head word
    assign out_valid = (cnt != '0);
    assign free_cnt  = cnt_w'(depth) - cnt;

    ////////////////////
    // pointers and count
    ////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            cnt      <= '0;
            in_ready <= 1'b0;               // opens on first edge after release
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;    // wraps at depth
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            cnt      <= cnt_nxt;
            // registered so in_ready has no path from out_ready
            in_ready <= (cnt_nxt != cnt_w'(depth));
        end
    end

endmodule

// ==== logic/ft_bus_arbiter.sv ====
`timescale 1ns/1ps

// sequencer for the shared ft601 data bus
// idle -> bta -> read, or idle -> write, back to idle between grants
module ft_bus_arbiter
    import ft_bus_pkg::*;
#(
    parameter int max_burst = 8     // data cycles per grant
) (
    input  logic clk,
    input  logic arst_n,
    input  logic tx_req,            // tx fifo holds a word
    input  logic rx_req,            // rx fifo has room for two
    input  logic txe_n,             // chip has space, active low
    input  logic rxf_n,             // chip has data, active low
    output logic tx_grant,
    output logic rx_grant,
    output logic oe_n,
    output logic rd_n,
    output logic data_oe            // fpga drives data/be
);

    localparam int burst_w = $clog2(max_burst + 1);

    bus_state_t          state;
    bus_state_t          state_nxt;
    bus_dir_t            last_dir;       // who was served last
    bus_dir_t            last_dir_nxt;
    logic [burst_w-1:0]  burst_cnt;      // cycles spent in read or write
    logic                rd_ok;
    logic                wr_ok;
    logic                burst_end;
    logic                pick_rd;

    ////////////////////
    // request qualify
    ////////////////////

    assign rd_ok     = rx_req && !rxf_n;
    assign wr_ok     = tx_req && !txe_n;
    assign burst_end = (burst_cnt == burst_w'(max_burst - 1));   // last allowed cycle

    // round robin, read wins a tie unless it went last
    assign pick_rd = rd_ok && (!wr_ok || (last_dir == dir_tx));

    ////////////////////
    // next state
    ////////////////////

    always_comb begin
        state_nxt    = state;
        last_dir_nxt = last_dir;
        case (state)
            st_idle: begin
                if (pick_rd) begin
                    state_nxt    = st_bta;      // chip needs a turnaround first
                    last_dir_nxt = dir_rx;
                end else if (wr_ok) begin
                    state_nxt    = st_write;    // fpga already owns the bus
                    last_dir_nxt = dir_tx;
                end
            end
            st_bta: begin
                // request may have gone away during turnaround
                state_nxt = rd_ok ? st_read : st_idle;
            end
            st_read: begin
                if (!rd_ok || burst_end) begin
                    state_nxt = st_idle;
                end
            end
            st_write: begin
                if (!wr_ok || burst_end) begin
                    state_nxt = st_idle;
                end
            end
            default: begin
                state_nxt = st_idle;
            end
        endcase
    end

    ////////////////////
    // registers
    ////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= st_idle;
            last_dir  <= dir_tx;        // first tie goes to read
            burst_cnt <= '0;
        end else begin
            state    <= state_nxt;
            last_dir <= last_dir_nxt;
            // count only while a data state is held
            if ((state == st_read || state == st_write) && (state_nxt == state)) begin
                burst_cnt <= burst_cnt + 1'b1;
            end else begin
                burst_cnt <= '0;
            end
        end
    end

    ////////////////////
    // bus controls
    ////////////////////

    assign tx_grant = (state == st_write);
    assign rx_grant = (state == st_read);
    assign rd_n     = !rx_grant;                       // low only in st_read
    assign oe_n     = !((state == st_bta) || rx_grant); // chip drives in bta and read
    assign data_oe  = tx_grant;                        // never overlaps oe_n low

endmodule

// ==== logic/ft_tx_port.sv ====
`timescale 1ns/1ps

// host bound words, stream in and chip write strobes out
module ft_tx_port
    import ft_bus_pkg::*;
    import ft_stream_pkg::*;
#(
    parameter int fifo_depth = 16
) (
    input  logic                  clk,
    input  logic                  arst_n,
    // input stream
    input  logic [bus_data_w-1:0] in_data,
    input  logic [bus_be_w-1:0]   in_be,
    input  logic                  in_valid,
    output logic                  in_ready,
    // arbiter
    input  logic                  tx_grant,
    input  logic                  txe_n,
    output logic                  tx_req,
    // chip side
    output logic [bus_data_w-1:0] data_out,
    output logic [bus_be_w-1:0]   be_out,
    output logic                  wr_n
);

    stream_word_t  in_word;
    stream_word_t  head_word;
    logic          head_valid;
    logic          wr_go;           // one word goes to the chip

    assign in_word.data = in_data;
    assign in_word.be   = in_be;

    word_fifo #(
        .payload_t (stream_word_t),
        .depth     (fifo_depth)
    ) tx_fifo_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_word   (in_word),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_word  (head_word),
        .out_valid (head_valid),
        .out_ready (wr_go),         // pop on every strobe
        .free_cnt  ()
    );

    assign tx_req = head_valid;

    // granted, chip has room, something to send
    assign wr_go = tx_grant && !txe_n && head_valid;
    assign wr_n  = !wr_go;

    // head word sits on the bus, data_oe gates it at the pads
    assign data_out = head_word.data;
    assign be_out   = head_word.be;

endmodule

// ==== logic/ft_rx_port.sv ====
`timescale 1ns/1ps

// device bound words, chip reads in and stream out
module ft_rx_port
    import ft_bus_pkg::*;
    import ft_stream_pkg::*;
#(
    parameter int fifo_depth = 16
) (
    input  logic                  clk,
    input  logic                  arst_n,
    // chip side
    input  logic [bus_data_w-1:0] data_in,
    input  logic [bus_be_w-1:0]   be_in,
    input  logic                  rxf_n,
    input  logic                  rd_n,      // from the arbiter
    output logic                  rx_req,
    // output stream
    output logic [bus_data_w-1:0] out_data,
    output logic [bus_be_w-1:0]   out_be,
    output logic                  out_valid,
    input  logic                  out_ready
);

    localparam int cnt_w = $clog2(fifo_depth + 1);

    stream_word_t      cap_word;
    stream_word_t      head_word;
    logic              cap_valid;    // chip word on the bus this cycle
    logic [cnt_w-1:0]  free_cnt;

    assign cap_word.data = data_in;
    assign cap_word.be   = be_in;

    // a word is only there when both strobes are low
    assign cap_valid = !rd_n && !rxf_n;

    word_fifo #(
        .payload_t (stream_word_t),
        .depth     (fifo_depth)
    ) rx_fifo_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_word   (cap_word),
        .in_valid  (cap_valid),
        .in_ready  (),               // margin below keeps it open
        .out_word  (head_word),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .free_cnt  (free_cnt)
    );

    // two free slots, rd_n stays low one cycle after the stop decision
    assign rx_req = (free_cnt >= cnt_w'(2));

    assign out_data = head_word.data;
    assign out_be   = head_word.be;

endmodule

// ==== logic/ft601_bridge.sv ====
`timescale 1ns/1ps

// ft601 245 sync fifo bridge, single clock, pad tristate outside
module ft601_bridge
    import ft_bus_pkg::*;
    import ft_stream_pkg::*;
#(
    parameter int fifo_depth = default_fifo_depth,   // both ports
    parameter int max_burst  = 8
) (
    input  logic                  clk,               // also the chip clock
    input  logic                  arst_n,
    // stream toward the chip
    input  logic [bus_data_w-1:0] in_data,
    input  logic [bus_be_w-1:0]   in_be,
    input  logic                  in_valid,
    output logic                  in_ready,
    // stream from the chip
    output logic [bus_data_w-1:0] out_data,
    output logic [bus_be_w-1:0]   out_be,
    output logic                  out_valid,
    input  logic                  out_ready,
    // chip pins, split direction
    input  logic [bus_data_w-1:0] data_in,
    input  logic [bus_be_w-1:0]   be_in,
    input  logic                  txe_n,
    input  logic                  rxf_n,
    output logic [bus_data_w-1:0] data_out,
    output logic [bus_be_w-1:0]   be_out,
    output logic                  data_oe,
    output logic                  oe_n,
    output logic                  rd_n,
    output logic                  wr_n
);

    logic tx_req;
    logic rx_req;
    logic tx_grant;

    ft_tx_port #(.fifo_depth(fifo_depth)) tx_port_i (
        .clk(clk), .arst_n(arst_n),
        .in_data(in_data), .in_be(in_be), .in_valid(in_valid), .in_ready(in_ready),
        .tx_grant(tx_grant), .txe_n(txe_n), .tx_req(tx_req),
        .data_out(data_out), .be_out(be_out), .wr_n(wr_n)
    );

    ft_rx_port #(.fifo_depth(fifo_depth)) rx_port_i (
        .clk(clk), .arst_n(arst_n),
        .data_in(data_in), .be_in(be_in), .rxf_n(rxf_n), .rd_n(rd_n), .rx_req(rx_req),
        .out_data(out_data), .out_be(out_be), .out_valid(out_valid), .out_ready(out_ready)
    );

    ft_bus_arbiter #(.max_burst(max_burst)) arbiter_i (
        .clk(clk), .arst_n(arst_n),
        .tx_req(tx_req), .rx_req(rx_req), .txe_n(txe_n), .rxf_n(rxf_n),
        .tx_grant(tx_grant), .rx_grant(),    // read grant travels as rd_n
        .oe_n(oe_n), .rd_n(rd_n), .data_oe(data_oe)
    );

endmodule

// ==== sim/ft601_bridge_sva.sv ====
`timescale 1ns/1ps

// protocol checks on the ft601 pins, bound into the bridge top
module ft601_bridge_sva (
    input logic clk,
    input logic arst_n,
    input logic oe_n,
    input logic rd_n,
    input logic wr_n,
    input logic data_oe,
    input logic txe_n,
    input logic out_valid
);

    int fail_cnt = 0;   // read by the testbench at the end

    ////////////////////
    // reset
    ////////////////////

    reset_quiet: assert property (@(posedge clk)
        !arst_n |-> (oe_n && rd_n && wr_n && !data_oe && !out_valid))
        else begin
            fail_cnt++;
            $error("bus strobes active while reset is held");
        end

    ////////////////////
    // bus ownership
    ////////////////////

    // chip needs one turnaround cycle with oe_n low before rd_n
    rd_after_oe: assert property (@(posedge clk) disable iff (!arst_n)
        $fell(rd_n) |-> !$past(oe_n))
        else begin
            fail_cnt++;
            $error("rd_n fell without a turnaround cycle");
        end

    no_drive_clash: assert property (@(posedge clk) disable iff (!arst_n)
        !(data_oe && !oe_n))   // both sides would drive the bus
        else begin
            fail_cnt++;
            $error("fpga drives the bus while the chip owns it");
        end

    one_strobe: assert property (@(posedge clk) disable iff (!arst_n)
        !(!rd_n && !wr_n))
        else begin
            fail_cnt++;
            $error("rd_n and wr_n low together");
        end

    wr_needs_space: assert property (@(posedge clk) disable iff (!arst_n)
        !wr_n |-> !txe_n)
        else begin
            fail_cnt++;
            $error("write strobe while the chip is full");
        end

endmodule

bind ft601_bridge ft601_bridge_sva sva_i (
    .clk(clk), .arst_n(arst_n), .oe_n(oe_n), .rd_n(rd_n), .wr_n(wr_n),
    .data_oe(data_oe), .txe_n(txe_n), .out_valid(out_valid)
);

// ==== sim/tb_ft601_bridge.sv ====
`timescale 1ns/1ps

module tb_ft601_bridge
    import ft_bus_pkg::*;
    import ft_stream_pkg::*;
();

    localparam int fifo_depth = 16;
    localparam int max_burst  = 8;
    localparam int n_words    = 64;
    localparam int timeout    = 20000;   // cycles per wait

    logic clk = 1'b0;
    logic arst_n;
    logic [bus_data_w-1:0] in_data, out_data, data_in, data_out;
    logic [bus_be_w-1:0]   in_be, out_be, be_in, be_out;
    logic in_valid, in_ready, out_valid, out_ready;
    logic txe_n, rxf_n, data_oe, oe_n, rd_n, wr_n;

    integer seed = 32'h531c_207b;
    string  cur_test;
    int     err_cnt = 0;
    int     err_mark = 0;
    int     test_cnt = 0;
    stream_word_t tx_pool[$];     // random words for the input stream
    stream_word_t send_q[$];      // not yet accepted by the bridge
    stream_word_t exp_tx_q[$];    // not yet seen on the chip bus
    int rx_limit = 0;             // words the chip model may hand out
    int rx_sent = 0;
    int rx_got = 0;
    int tx_accepted = 0;
    int rd_run = 0, wr_run = 0, rd_low_total = 0;
    int txe_mode = 2, rxf_mode = 2, rdy_mode = 1;   // 0 random, 1 open, 2 blocked

    always #5 clk = ~clk;

    ft601_bridge #(.fifo_depth(fifo_depth), .max_burst(max_burst)) dut_i (
        .clk(clk), .arst_n(arst_n),
        .in_data(in_data), .in_be(in_be), .in_valid(in_valid), .in_ready(in_ready),
        .out_data(out_data), .out_be(out_be), .out_valid(out_valid), .out_ready(out_ready),
        .data_in(data_in), .be_in(be_in), .txe_n(txe_n), .rxf_n(rxf_n),
        .data_out(data_out), .be_out(be_out), .data_oe(data_oe),
        .oe_n(oe_n), .rd_n(rd_n), .wr_n(wr_n)
    );

    // numbered word k that the chip model hands out on reads
    function automatic stream_word_t rx_word_at(input int k);
        stream_word_t w;
        w.data = {16'hc0de ^ k[15:0], k[15:0]};
        w.be   = k[3:0] | 4'b0001;   // at least one lane
        return w;
    endfunction

    task automatic note_failure(input string msg);
        $display("%s: %s", cur_test, msg);
        err_cnt++;
    endtask

    task automatic compare_word(input string what,
                                input stream_word_t exp,
                                input stream_word_t act);
        assert (act == exp) else begin
            $display("[ERROR] %s: %s expected %h actual %h", cur_test, what, exp, act);
            err_cnt++;
        end
    endtask

    task automatic compare_int(input string what, input int exp, input int act);
        assert (act == exp) else begin
            $display("[ERROR] %s: %s expected %0d actual %0d", cur_test, what, exp, act);
            err_cnt++;
        end
    endtask

    task automatic finish_test();
        test_cnt++;
        $display("test %s: %s", cur_test, (err_cnt == err_mark) ? "ok" : "FAILED");
        err_mark = err_cnt;
    endtask

    task automatic queue_tx(input int n);
        repeat (n) begin
            send_q.push_back(tx_pool[0]);
            exp_tx_q.push_back(tx_pool.pop_front());
        end
    endtask

    task automatic wait_tx_drain();
        int t;
        t = 0;
        while ((exp_tx_q.size() != 0 || send_q.size() != 0) && t < timeout) begin
            @(posedge clk);
            t++;
        end
        if (exp_tx_q.size() != 0 || send_q.size() != 0)
            note_failure("timeout, chip did not receive every sent word");
    endtask

    task automatic wait_rx_done();
        int t;
        t = 0;
        while (rx_got < rx_limit && t < timeout) begin
            @(posedge clk);
            t++;
        end
        if (rx_got < rx_limit) note_failure("timeout, stream output missed chip words");
    endtask

    task automatic check_quiet_bus();
        compare_int("oe_n", 1, oe_n);
        compare_int("rd_n", 1, rd_n);
        compare_int("wr_n", 1, wr_n);
        compare_int("data_oe", 0, data_oe);
        compare_int("out_valid", 0, out_valid);
        compare_int("in_ready", 0, in_ready);
    endtask

    ////////////////////
    // input stream source
    ////////////////////

    always @(posedge clk) begin
        if (in_valid && in_ready) begin
            void'(send_q.pop_front());
            tx_accepted++;
        end
        in_valid <= (send_q.size() != 0);   // held until accepted
        if (send_q.size() != 0) begin
            in_data <= send_q[0].data;
            in_be   <= send_q[0].be;
        end
    end

    ////////////////////
    // ft601 model and sink, all random draws here
    ////////////////////

    always @(posedge clk) begin
        int nxt;
        stream_word_t nw;
        nxt = rx_sent;
        if (arst_n) begin
            if (!rd_n && !rxf_n) nxt++;     // chip word taken this edge
            nw = rx_word_at(nxt);
            rx_sent <= nxt;
            data_in <= nw.data;
            be_in   <= nw.be;
            if (nxt >= rx_limit) rxf_n <= 1'b1;
            else rxf_n <= (rxf_mode == 0) ? (($random(seed) & 3) == 0) : (rxf_mode == 2);
            txe_n <= (txe_mode == 0) ? (($random(seed) & 3) == 0) : (txe_mode == 2);
            out_ready <= (rdy_mode == 0) ? (($random(seed) & 1) != 0) : (rdy_mode == 1);
        end
    end

    // chip writes, stream output, burst runs
    always @(posedge clk) begin
        stream_word_t w;
        if (arst_n) begin
            if (!wr_n) begin
                w.data = data_out;
                w.be   = be_out;
                compare_int("data_oe on write", 1, data_oe);   // pads must drive
                if (exp_tx_q.size() == 0) note_failure("write strobe with no word pending");
                else compare_word("chip write", exp_tx_q.pop_front(), w);
            end
            if (out_valid && out_ready) begin
                w.data = out_data;
                w.be   = out_be;
                assert (rx_got < rx_sent) else note_failure("stream word the chip never gave");
                compare_word("stream out", rx_word_at(rx_got), w);
                rx_got++;
            end
            rd_run = rd_n ? 0 : rd_run + 1;
            wr_run = wr_n ? 0 : wr_run + 1;
            if (!rd_n) rd_low_total++;
            assert (rd_run <= max_burst) else compare_int("rd_n low run", max_burst, rd_run);
            assert (wr_run <= max_burst) else compare_int("wr_n low run", max_burst, wr_run);
        end
    end

    ////////////////////
    // test sequence
    ////////////////////

    initial begin
        stream_word_t w;
        int base, snap, snap_rd;
        in_valid  = 0;
        in_data   = '0;
        in_be     = '0;
        out_ready = 1'b1;
        txe_n = 1'b1;
        rxf_n = 1'b1;
        w = rx_word_at(0);
        data_in = w.data;
        be_in   = w.be;
        repeat (2 * n_words + 2 * fifo_depth) begin
            w.data = $random(seed);
            w.be   = 4'($random(seed));
            tx_pool.push_back(w);
        end

        cur_test = "reset";
        arst_n = 1'b0;
        repeat (2) @(posedge clk);
        check_quiet_bus();
        arst_n <= 1'b1;
        @(posedge clk);
        check_quiet_bus();                  // still quiet at first edge after release
        finish_test();

        cur_test = "host_to_device";
        txe_mode = 0; rdy_mode = 0;
        queue_tx(n_words);
        wait_tx_drain();
        finish_test();

        cur_test = "device_to_host";
        rxf_mode = 0;
        rx_limit += n_words;
        wait_rx_done();
        finish_test();

        cur_test = "fairness";              // both sides pending all the time
        txe_mode = 1; rxf_mode = 1; rdy_mode = 1;
        queue_tx(n_words);
        rx_limit += n_words;
        wait_tx_drain();
        wait_rx_done();
        finish_test();

        cur_test = "rx_full";
        txe_mode = 2; rdy_mode = 2;
        base = rx_sent;
        rx_limit += 3 * fifo_depth;
        repeat (4 * fifo_depth) @(posedge clk);
        snap = rx_sent;
        snap_rd = rd_low_total;
        assert (snap - base >= fifo_depth - 1 && snap - base <= fifo_depth)
            else compare_int("words taken while stalled", fifo_depth, snap - base);
        repeat (2 * fifo_depth) @(posedge clk);
        compare_int("words taken after fill", snap, rx_sent);
        compare_int("read cycles after fill", snap_rd, rd_low_total);
        rdy_mode = 0; rxf_mode = 0;
        wait_rx_done();
        finish_test();

        cur_test = "tx_full";
        rxf_mode = 2;
        base = tx_accepted;
        queue_tx(2 * fifo_depth);
        snap = 0;
        while (tx_accepted - base < fifo_depth && snap < timeout) begin
            @(posedge clk);
            snap++;
        end
        repeat (4) @(posedge clk);
        compare_int("accepted with chip full", fifo_depth, tx_accepted - base);
        compare_int("in_ready with fifo full", 0, in_ready);
        txe_mode = 0;
        wait_tx_drain();
        finish_test();

        repeat (5) @(posedge clk);
        err_cnt += dut_i.sva_i.fail_cnt;
        $display("tests %0d, errors %0d, protocol errors %0d",
                 test_cnt, err_cnt, dut_i.sva_i.fail_cnt);
        if (err_cnt == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
logic/ft_bus_pkg.sv
logic/ft_stream_pkg.sv
logic/word_fifo.sv
logic/ft_bus_arbiter.sv
logic/ft_tx_port.sv
logic/ft_rx_port.sv
logic/ft601_bridge.sv
sim/ft601_bridge_sva.sv
sim/tb_ft601_bridge.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the ft601 bridge testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f --top-module tb_ft601_bridge \
    -Mdir obj_dir -o tb_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat build.log
    echo "build failed with status $status"
    exit 1
fi

./obj_dir/tb_sim +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Done: errors found" sim.log; then
    exit 1
fi
exit 0
